//--- hw/umi_pkg.sv
// umi package: bus widths, opcodes and command word field positions
package umi_pkg;

   //####################################################################
   // bus widths
   //####################################################################
   localparam int UMI_AW = 64;         // address width
   localparam int UMI_CW = 32;         // command width
   localparam int UMI_RW = 32;         // register data width

   //####################################################################
   // command word layout
   //####################################################################
   localparam int CMD_OPCODE_LSB = 0;  // opcode [4:0]
   localparam int CMD_SIZE_LSB   = 5;  // size [7:5]
   localparam int CMD_LEN_LSB    = 8;  // length [15:8]

   localparam int OPCODE_W = 5;
   localparam int SIZE_W   = 3;
   localparam int LEN_W    = 8;

   //####################################################################
   // opcodes
   //####################################################################
   // requests, odd codes
   localparam logic [OPCODE_W-1:0] OP_REQ_RD     = 5'd1;  // read
   localparam logic [OPCODE_W-1:0] OP_REQ_WR     = 5'd3;  // write, acked
   localparam logic [OPCODE_W-1:0] OP_REQ_POSTED = 5'd5;  // write, no response

   // responses, even codes
   localparam logic [OPCODE_W-1:0] OP_RESP_RD = 5'd2;     // read data
   localparam logic [OPCODE_W-1:0] OP_RESP_WR = 5'd4;     // write ack

endpackage

//--- hw/link_cfg_pkg.sv
// link config package: register map, field layout, reset values, credit sizing
package link_cfg_pkg;

   //####################################################################
   // register map, byte offsets, decoded on addr[7:2]
   //####################################################################
   localparam logic [7:0] REG_CTRL       = 8'h00;
   localparam logic [7:0] REG_STATUS     = 8'h04;
   localparam logic [7:0] REG_TXMODE     = 8'h10;
   localparam logic [7:0] REG_RXMODE     = 8'h14;
   localparam logic [7:0] REG_CRDTINIT   = 8'h20;
   localparam logic [7:0] REG_CRDTINTRVL = 8'h24;
   localparam logic [7:0] REG_CRDTSTAT   = 8'h28;  // read only, external

   //####################################################################
   // fields
   //####################################################################
   localparam int CTRL_ARBMODE_LSB  = 4;   // arbiter mode, 2 bits
   localparam int ARBMODE_W         = 2;
   localparam int STATUS_LINK_BIT   = 4;   // live link state
   localparam int MODE_EN_BIT       = 0;   // tx/rx enable
   localparam int TXMODE_CRDTEN_BIT = 4;   // credit updates on
   localparam int MODE_IOW_LSB      = 16;  // io width code, 8 bits
   localparam int IOW_W             = 8;

   // credit update interval after reset
   localparam logic [15:0] CRDT_INTRVL_RESET = 16'h0010;

   //####################################################################
   // credit sizing
   //####################################################################
   localparam int RX_FIFO_W = 8;             // bits per rx fifo
   localparam int N_FIFO    = 8;             // parallel rx fifos
   localparam int PKT_W     = 128 + 64 + 64 + 32;  // data + two addr + cmd
   // one spare slot plus each lane's share of a full packet
   localparam int CRDT_DEPTH = 1 + (PKT_W / RX_FIFO_W) / N_FIFO;
   localparam logic [15:0] TOT_CRDT = 16'(CRDT_DEPTH * N_FIFO);  // 40

endpackage

//--- hw/reg_bus_if.sv
`timescale 1ns/1ps
// register strobe bus between the umi endpoint and the register file
interface reg_bus_if;
   import umi_pkg::*;

   logic [UMI_AW-1:0] addr;    // full request address, regs decode [7:2]
   logic              write;   // one-cycle write strobe
   logic              read;    // one-cycle read strobe
   logic [UMI_RW-1:0] wrdata;  // write payload
   logic [UMI_RW-1:0] rddata;  // valid the cycle after read

   // endpoint side
   modport master
     (
      output addr,
      output write,
      output read,
      output wrdata,
      input  rddata
      );

   // register file side
   modport slave
     (
      input  addr,
      input  write,
      input  read,
      input  wrdata,
      output rddata
      );

endinterface

//--- hw/umi_reg_endpoint.sv
`timescale 1ns/1ps
// umi register endpoint: single request intake, register strobes, response builder
module umi_reg_endpoint
  (
   input  logic                       clk,
   input  logic                       nreset,
   // request from host
   input  logic                       req_valid,
   input  logic [umi_pkg::UMI_CW-1:0] req_cmd,
   input  logic [umi_pkg::UMI_AW-1:0] req_dstaddr,
   input  logic [umi_pkg::UMI_AW-1:0] req_srcaddr,
   input  logic [umi_pkg::UMI_RW-1:0] req_data,
   output logic                       req_ready,
   // response to host
   output logic                       resp_valid,
   output logic [umi_pkg::UMI_CW-1:0] resp_cmd,
   output logic [umi_pkg::UMI_AW-1:0] resp_dstaddr,
   output logic [umi_pkg::UMI_AW-1:0] resp_srcaddr,
   output logic [umi_pkg::UMI_RW-1:0] resp_data,
   input  logic                       resp_ready,
   // register side
   reg_bus_if.master                  bus
   );

   import umi_pkg::*;

   logic [OPCODE_W-1:0] req_opcode;
   logic                req_fire;      // request transfer this cycle
   logic                is_read;
   logic                is_ackwrite;
   logic                is_posted;
   logic                need_resp;     // read or acked write
   logic [UMI_CW-1:0]   resp_cmd_next;
   logic                resp_pend;     // response waiting for host
   logic                resp_is_read;  // selects rddata onto resp_data

   //####################################################################
   // request decode
   //####################################################################
   assign req_opcode  = req_cmd[CMD_OPCODE_LSB +: OPCODE_W];
   assign is_read     = (req_opcode == OP_REQ_RD);
   assign is_ackwrite = (req_opcode == OP_REQ_WR);
   assign is_posted   = (req_opcode == OP_REQ_POSTED);
   assign need_resp   = is_read | is_ackwrite;

   assign req_ready = ~resp_pend;              // one request in flight
   assign req_fire  = req_valid & req_ready;

   // strobes go out in the accept cycle, unknown opcodes dropped
   assign bus.read   = req_fire & is_read;
   assign bus.write  = req_fire & (is_ackwrite | is_posted);
   assign bus.addr   = req_dstaddr;
   assign bus.wrdata = req_data;

   //####################################################################
   // response
   //####################################################################
   always_comb
   begin
      resp_cmd_next = '0;                      // unused cmd bits zero
      resp_cmd_next[CMD_OPCODE_LSB +: OPCODE_W] = is_read ? OP_RESP_RD : OP_RESP_WR;
      resp_cmd_next[CMD_SIZE_LSB +: SIZE_W] = req_cmd[CMD_SIZE_LSB +: SIZE_W];
      resp_cmd_next[CMD_LEN_LSB +: LEN_W]   = req_cmd[CMD_LEN_LSB +: LEN_W];
   end

   // pending flag, set on accept, cleared on host handshake
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         resp_pend    <= 1'b0;
         resp_is_read <= 1'b0;
      end
      else if (req_fire && need_resp)
      begin
         resp_pend    <= 1'b1;
         resp_is_read <= is_read;
      end
      else if (resp_pend && resp_ready)
         resp_pend <= 1'b0;

   // payload held while pending, addresses swapped
   always_ff @(posedge clk)
      if (req_fire && need_resp)
      begin
         resp_cmd     <= resp_cmd_next;
         resp_dstaddr <= req_srcaddr;          // back to requester
         resp_srcaddr <= req_dstaddr;
      end

   assign resp_valid = resp_pend;

   // rddata lands with resp_valid and stays put, no reads while pending
   assign resp_data = resp_is_read ? bus.rddata : '0;

endmodule

//--- hw/link_state_tracker.sv
`timescale 1ns/1ps
// link state tracker: qualified link-active level and its rising-edge pulse
module link_state_tracker
  (
   input  logic clk,
   input  logic nreset,
   input  logic device_mode,     // 1 = device side
   input  logic device_ready,    // brick controller ready
   input  logic phy_linkactive,  // raw level from phy
   output logic link_active,
   output logic link_rise        // one-cycle pulse
   );

   logic link_qual;    // sampling allowed
   logic link_dly;     // link_active one cycle back

   // host always samples, device waits for ready
   assign link_qual = ~device_mode | device_ready;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         link_active <= 1'b0;
      else if (link_qual)
         link_active <= phy_linkactive;   // else hold last state

   //####################################################################
   // edge detect, registered so the pulse trails link_active by one
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         link_dly  <= 1'b0;
         link_rise <= 1'b0;
      end
      else
      begin
         link_dly  <= link_active;
         link_rise <= link_active & ~link_dly;
      end

endmodule

//--- hw/link_ctrl_regs.sv
`timescale 1ns/1ps
// link control registers: config state, write decode, read mux, link control levels
module link_ctrl_regs
  (
   input  logic        clk,
   input  logic        nreset,
   reg_bus_if.slave    bus,
   // link state
   input  logic        link_active,
   input  logic        link_rise,             // load defaults
   input  logic [7:0]  phy_iow,               // phy io width code
   input  logic [31:0] csr_txcrdt_status,     // read back only
   // control levels
   output logic [1:0]  csr_arbmode,
   output logic        csr_txen,
   output logic        csr_txcrdt_en,
   output logic [7:0]  csr_txiowidth,
   output logic        csr_rxen,
   output logic [7:0]  csr_rxiowidth,
   output logic [15:0] csr_txcrdt_intrvl,
   output logic [15:0] csr_rxcrdt_req_init,
   output logic [15:0] csr_rxcrdt_resp_init
   );

   import umi_pkg::*;
   import link_cfg_pkg::*;

   logic [UMI_RW-1:0] ctrl_reg;
   logic [UMI_RW-1:0] status_word;       // live, no storage
   logic [UMI_RW-1:0] txmode_reg;
   logic [UMI_RW-1:0] rxmode_reg;
   logic [UMI_RW-1:0] crdt_init_reg;     // resp [31:16], req [15:0]
   logic [15:0]       crdt_intrvl_reg;

   logic [UMI_RW-1:0] txmode_dflt;
   logic [UMI_RW-1:0] rxmode_dflt;
   logic [15:0]       crdt_dflt;

   logic [5:0]        word_sel;          // addr[7:2]
   logic              wr_ctrl;
   logic              wr_txmode;
   logic              wr_rxmode;
   logic              wr_crdt_init;
   logic              wr_crdt_intrvl;

   //####################################################################
   // write decode
   //####################################################################
   assign word_sel       = bus.addr[7:2];
   assign wr_ctrl        = bus.write & (word_sel == REG_CTRL[7:2]);
   assign wr_txmode      = bus.write & (word_sel == REG_TXMODE[7:2]);
   assign wr_rxmode      = bus.write & (word_sel == REG_RXMODE[7:2]);
   assign wr_crdt_init   = bus.write & (word_sel == REG_CRDTINIT[7:2]);
   assign wr_crdt_intrvl = bus.write & (word_sel == REG_CRDTINTRVL[7:2]);
   // status is read only, writes to it fall through

   //####################################################################
   // link-up defaults, sampled from phy
   //####################################################################
   always_comb
   begin
      txmode_dflt = '0;
      txmode_dflt[MODE_IOW_LSB +: IOW_W] = phy_iow;
      txmode_dflt[TXMODE_CRDTEN_BIT]     = 1'b1;
      txmode_dflt[MODE_EN_BIT]           = 1'b1;
      rxmode_dflt = '0;
      rxmode_dflt[MODE_IOW_LSB +: IOW_W] = phy_iow;
      rxmode_dflt[MODE_EN_BIT]           = 1'b1;
   end

   // credits scale with io width, truncated to 16 bits
   assign crdt_dflt = TOT_CRDT << phy_iow;

   //####################################################################
   // registers, link_rise wins over a write in the same cycle
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         ctrl_reg <= '0;
      else if (wr_ctrl)
         ctrl_reg <= bus.wrdata;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         txmode_reg    <= '0;
         rxmode_reg    <= '0;
         crdt_init_reg <= '0;
      end
      else if (link_rise)
      begin
         txmode_reg    <= txmode_dflt;
         rxmode_reg    <= rxmode_dflt;
         crdt_init_reg <= {crdt_dflt, crdt_dflt};   // resp, req
      end
      else
      begin
         if (wr_txmode)
            txmode_reg <= bus.wrdata;
         if (wr_rxmode)
            rxmode_reg <= bus.wrdata;
         if (wr_crdt_init)
            crdt_init_reg <= bus.wrdata;
      end

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         crdt_intrvl_reg <= CRDT_INTRVL_RESET;
      else if (wr_crdt_intrvl)
         crdt_intrvl_reg <= bus.wrdata[15:0];   // upper half dropped

   always_comb
   begin
      status_word = '0;
      status_word[STATUS_LINK_BIT] = link_active;
   end

   //####################################################################
   // read mux, registered on the read strobe
   //####################################################################
   always_ff @(posedge clk)
      if (bus.read)
         case (word_sel)
            REG_CTRL[7:2]       : bus.rddata <= ctrl_reg;
            REG_STATUS[7:2]     : bus.rddata <= status_word;
            REG_TXMODE[7:2]     : bus.rddata <= txmode_reg;
            REG_RXMODE[7:2]     : bus.rddata <= rxmode_reg;
            REG_CRDTINIT[7:2]   : bus.rddata <= crdt_init_reg;
            REG_CRDTINTRVL[7:2] : bus.rddata <= {16'h0000, crdt_intrvl_reg};
            REG_CRDTSTAT[7:2]   : bus.rddata <= csr_txcrdt_status;
            default             : bus.rddata <= '0;   // unmapped
         endcase

   //####################################################################
   // control outputs
   //####################################################################
   assign csr_arbmode   = ctrl_reg[CTRL_ARBMODE_LSB +: ARBMODE_W];
   assign csr_txen      = link_active & txmode_reg[MODE_EN_BIT];  // off when link down
   assign csr_txcrdt_en = txmode_reg[TXMODE_CRDTEN_BIT];
   assign csr_txiowidth = txmode_reg[MODE_IOW_LSB +: IOW_W];
   assign csr_rxen      = link_active & rxmode_reg[MODE_EN_BIT];
   assign csr_rxiowidth = rxmode_reg[MODE_IOW_LSB +: IOW_W];

   assign csr_txcrdt_intrvl    = crdt_intrvl_reg;
   assign csr_rxcrdt_req_init  = crdt_init_reg[15:0];
   assign csr_rxcrdt_resp_init = crdt_init_reg[31:16];

endmodule

//--- hw/link_ctrl_top.sv
`timescale 1ns/1ps
// link control top: umi register port, link tracking and control register file
module link_ctrl_top
  (
   input  logic                       clk,
   input  logic                       nreset,
   input  logic                       devicemode,      // 1 = device side
   input  logic                       deviceready,
   // phy
   input  logic                       phy_linkactive,
   input  logic [7:0]                 phy_iow,
   // umi request
   input  logic                       req_valid,
   input  logic [umi_pkg::UMI_CW-1:0] req_cmd,
   input  logic [umi_pkg::UMI_AW-1:0] req_dstaddr,
   input  logic [umi_pkg::UMI_AW-1:0] req_srcaddr,
   input  logic [umi_pkg::UMI_RW-1:0] req_data,
   output logic                       req_ready,
   // umi response
   output logic                       resp_valid,
   output logic [umi_pkg::UMI_CW-1:0] resp_cmd,
   output logic [umi_pkg::UMI_AW-1:0] resp_dstaddr,
   output logic [umi_pkg::UMI_AW-1:0] resp_srcaddr,
   output logic [umi_pkg::UMI_RW-1:0] resp_data,
   input  logic                       resp_ready,
   // link controls
   output logic                       host_linkactive,
   output logic [1:0]                 csr_arbmode,
   output logic                       csr_txen,
   output logic                       csr_txcrdt_en,
   output logic [7:0]                 csr_txiowidth,
   output logic                       csr_rxen,
   output logic [7:0]                 csr_rxiowidth,
   output logic [15:0]                csr_txcrdt_intrvl,
   output logic [15:0]                csr_rxcrdt_req_init,
   output logic [15:0]                csr_rxcrdt_resp_init,
   input  logic [31:0]                csr_txcrdt_status
   );

   logic link_active;
   logic link_rise;

   reg_bus_if bus_i ();   // endpoint to register file

   umi_reg_endpoint endpoint_i
     (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .bus          (bus_i.master)
      );

   link_state_tracker tracker_i
     (
      .clk            (clk),
      .nreset         (nreset),
      .device_mode    (devicemode),
      .device_ready   (deviceready),
      .phy_linkactive (phy_linkactive),
      .link_active    (link_active),
      .link_rise      (link_rise)
      );

   link_ctrl_regs regs_i
     (
      .clk                  (clk),
      .nreset               (nreset),
      .bus                  (bus_i.slave),
      .link_active          (link_active),
      .link_rise            (link_rise),
      .phy_iow              (phy_iow),
      .csr_txcrdt_status    (csr_txcrdt_status),
      .csr_arbmode          (csr_arbmode),
      .csr_txen             (csr_txen),
      .csr_txcrdt_en        (csr_txcrdt_en),
      .csr_txiowidth        (csr_txiowidth),
      .csr_rxen             (csr_rxen),
      .csr_rxiowidth        (csr_rxiowidth),
      .csr_txcrdt_intrvl    (csr_txcrdt_intrvl),
      .csr_rxcrdt_req_init  (csr_rxcrdt_req_init),
      .csr_rxcrdt_resp_init (csr_rxcrdt_resp_init)
      );

   assign host_linkactive = link_active;   // qualified level out to host logic

endmodule

//--- testbench/tb_link_ctrl.sv
`timescale 1ns/1ps
// testbench for the link control block driving umi host requests and link bring-up
module tb_link_ctrl;
   import umi_pkg::*;
   import link_cfg_pkg::*;

   localparam logic [63:0] REG_BASE  = 64'h0000_0000_6000_0000;  // csr window
   localparam logic [63:0] HOST_ADDR = 64'h0000_00f0_0000_0100;  // response target
   localparam int          TIMEOUT   = 200;                      // cycles per wait

   // clock, reset and link inputs
   logic        clk;
   logic        nreset;
   logic        devicemode;
   logic        deviceready;
   logic        phy_linkactive;
   logic [7:0]  phy_iow;
   // umi handshake
   logic        req_valid;
   logic        req_ready;
   logic        resp_valid;
   logic        resp_ready;
   logic [31:0] req_cmd;
   logic [31:0] req_data;
   logic [31:0] resp_cmd;
   logic [31:0] resp_data;
   logic [63:0] req_dstaddr;
   logic [63:0] req_srcaddr;
   logic [63:0] resp_dstaddr;
   logic [63:0] resp_srcaddr;
   // control levels out of the dut
   logic        host_linkactive;
   logic        csr_txen;
   logic        csr_txcrdt_en;
   logic        csr_rxen;
   logic [7:0]  csr_txiowidth;
   logic [7:0]  csr_rxiowidth;
   logic [15:0] csr_txcrdt_intrvl;
   logic [15:0] csr_rxcrdt_req_init;
   logic [15:0] csr_rxcrdt_resp_init;
   logic [1:0]  csr_arbmode;
   logic [31:0] csr_txcrdt_status;   // fed back through REG_CRDTSTAT
   logic [31:0] lcg_state;
   int          errors;
   int          checks;

   link_ctrl_top dut_i (.*);

   always #20 clk = ~clk;   // 40 ns period

   //######################################################################
   // helpers
   //######################################################################
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic void report_failure(input string msg);
      errors++;
      $display("[ERROR] %s", msg);
   endfunction

   function automatic void check_val(input string name, input logic [63:0] exp_val,
                                     input logic [63:0] act_val);
      checks++;
      assert (act_val === exp_val)
      else
      begin
         errors++;
         $display("[ERROR] %s: expected %0h, actual %0h", name, exp_val, act_val);
      end
   endfunction

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      $display("%0d checks, %0d errors", checks, errors);
      $display("tests failed");
      $finish;
   endtask

   task automatic wait_link(input logic level);
      int waited;
      waited = 0;
      @(negedge clk);
      while (host_linkactive !== level)
      begin
         waited++;
         if (waited > TIMEOUT)
            abort_run("host_linkactive never reached the wanted level");
         @(negedge clk);
      end
   endtask

   //######################################################################
   // umi host side
   //######################################################################
   task automatic send_request(input logic [4:0] op, input logic [7:0] off,
                               input logic [31:0] wdata);
      int waited;
      waited = 0;
      @(posedge clk);
      req_valid   <= 1'b1;
      req_cmd     <= {16'h0000, 8'h00, 3'd2, op};   // one word of 4 bytes
      req_dstaddr <= REG_BASE | {56'd0, off};
      req_srcaddr <= HOST_ADDR;
      req_data    <= wdata;
      @(negedge clk);
      while (!req_ready)
      begin
         waited++;
         if (waited > TIMEOUT)
            abort_run("req_ready stayed low");
         @(negedge clk);
      end
      @(posedge clk);        // transfer on this edge
      req_valid <= 1'b0;
   endtask

   task automatic collect_response(input logic [4:0] exp_op, input logic [7:0] off,
                                   output logic [31:0] data);
      int          waited;
      logic [31:0] rnd;
      waited = 0;
      rnd    = lcg_next();   // stall length in low bits
      @(negedge clk);
      while (!resp_valid)
      begin
         waited++;
         if (waited > TIMEOUT)
            abort_run("no response arrived");
         @(negedge clk);
      end
      check_val("resp cmd", 64'({8'h00, 3'd2, exp_op}), 64'(resp_cmd[15:0]));
      check_val("resp dstaddr", HOST_ADDR, resp_dstaddr);            // swapped
      check_val("resp srcaddr", REG_BASE | {56'd0, off}, resp_srcaddr);
      data = resp_data;
      repeat (rnd[1:0]) @(posedge clk);   // extra back-pressure
      @(posedge clk);
      resp_ready <= 1'b1;
      @(posedge clk);        // response transfer
      resp_ready <= 1'b0;
      @(negedge clk);
   endtask

   task automatic read_reg(input logic [7:0] off, output logic [31:0] data);
      send_request(OP_REQ_RD, off, 32'h0);
      collect_response(OP_RESP_RD, off, data);
   endtask

   task automatic write_reg(input logic [7:0] off, input logic [31:0] data);
      logic [31:0] ack_data;
      send_request(OP_REQ_WR, off, data);
      collect_response(OP_RESP_WR, off, ack_data);
      check_val("write ack data", 64'd0, 64'(ack_data));
   endtask

   task automatic post_write(input logic [7:0] off, input logic [31:0] data);
      send_request(OP_REQ_POSTED, off, data);
      repeat (3)
      begin
         @(negedge clk);
         check_val("posted write response", 64'd0, 64'(resp_valid));
      end
   endtask

   //######################################################################
   // protocol and output properties
   //######################################################################
   assert property (@(posedge clk) disable iff (!nreset) req_ready == !resp_valid)
      else report_failure("req_ready does not follow the pending response");
   assert property (@(posedge clk) disable iff (!nreset) resp_valid && !resp_ready |=>
         resp_valid && $stable(resp_cmd) && $stable(resp_dstaddr) &&
         $stable(resp_srcaddr) && $stable(resp_data))
      else report_failure("response dropped or changed under back-pressure");
   assert property (@(posedge clk) disable iff (!nreset)
         req_valid && req_ready && req_cmd[4:0] == OP_REQ_POSTED |=> !resp_valid)
      else report_failure("posted write produced a response");
   assert property (@(posedge clk) disable iff (!nreset) req_valid && req_ready &&
         (req_cmd[4:0] == OP_REQ_RD || req_cmd[4:0] == OP_REQ_WR) |=> resp_valid)
      else report_failure("response not raised one cycle after acceptance");
   assert property (@(posedge clk) disable iff (!nreset)
         csr_txen || csr_rxen |-> host_linkactive)
      else report_failure("tx or rx enabled while the link is down");
   assert property (@(posedge clk) disable iff (!nreset)   // device not ready holds link
         devicemode && !deviceready |=> $stable(host_linkactive))
      else report_failure("link level moved while device not ready");

   //######################################################################
   // test sequence
   //######################################################################
   initial
   begin
      logic [31:0] rd;
      logic [31:0] wr;
      logic [15:0] crdt;
      clk = 1'b0;
      nreset <= 1'b0;
      devicemode <= 1'b0;
      deviceready <= 1'b0;
      phy_linkactive <= 1'b0;
      phy_iow <= 8'd0;
      req_valid <= 1'b0;
      req_cmd <= 32'h0;
      req_dstaddr <= 64'h0;
      req_srcaddr <= 64'h0;
      req_data <= 32'h0;
      resp_ready <= 1'b0;
      csr_txcrdt_status <= 32'h0;
      errors = 0;
      checks = 0;
      lcg_state = 32'd53;
      repeat (8) @(posedge clk);
      nreset <= 1'b1;

      // reset state
      @(negedge clk);
      check_val("reset levels", 64'b100000, 64'({req_ready, resp_valid, host_linkactive,
                                                 csr_txen, csr_rxen, csr_txcrdt_en}));
      check_val("reset widths/credits", 64'd0, 64'({csr_txiowidth, csr_rxiowidth,
                                                   csr_rxcrdt_req_init, csr_rxcrdt_resp_init}));
      check_val("reset intrvl out", 64'h10, 64'(csr_txcrdt_intrvl));
      read_reg(REG_CTRL, rd);
      check_val("ctrl reset read", 64'd0, 64'(rd));
      read_reg(REG_CRDTINTRVL, rd);
      check_val("intrvl reset read", 64'h10, 64'(rd));

      // host mode bring-up at io width code 2
      @(posedge clk);
      phy_iow        <= 8'd2;
      phy_linkactive <= 1'b1;
      wait_link(1'b1);
      repeat (2) @(negedge clk);   // rise pulse then default load
      crdt = 16'd40 << 2;          // total credits scaled by width code
      check_val("bring-up enables", 64'hf, 64'({host_linkactive, csr_txen, csr_rxen,
                                                 csr_txcrdt_en}));
      check_val("bring-up iowidths", 64'h0202, 64'({csr_txiowidth, csr_rxiowidth}));
      check_val("bring-up credits", 64'({crdt, crdt}),
                64'({csr_rxcrdt_resp_init, csr_rxcrdt_req_init}));
      read_reg(REG_TXMODE, rd);
      check_val("txmode default", 64'h0002_0011, 64'(rd));   // iow field plus both enables
      read_reg(REG_RXMODE, rd);
      check_val("rxmode default", 64'h0002_0001, 64'(rd));
      read_reg(REG_CRDTINIT, rd);
      check_val("crdt init default", 64'({crdt, crdt}), 64'(rd));
      read_reg(REG_STATUS, rd);
      check_val("status link bit", 64'h10, 64'(rd));

      // device mode holds the link off until ready
      @(posedge clk);
      phy_linkactive <= 1'b0;
      wait_link(1'b0);
      @(posedge clk);
      devicemode     <= 1'b1;
      phy_linkactive <= 1'b1;
      repeat (6) @(negedge clk);
      check_val("device gated link", 64'd0, 64'(host_linkactive));
      @(posedge clk);
      deviceready <= 1'b1;
      wait_link(1'b1);
      repeat (2) @(negedge clk);   // defaults reload with the same width code

      // software writes and read back
      wr = lcg_next();
      write_reg(REG_CTRL, wr);
      read_reg(REG_CTRL, rd);
      check_val("ctrl readback", 64'(wr), 64'(rd));
      check_val("arbmode", 64'(wr[5:4]), 64'(csr_arbmode));
      wr = lcg_next();
      write_reg(REG_CRDTINTRVL, wr);
      read_reg(REG_CRDTINTRVL, rd);
      check_val("intrvl readback", 64'(wr[15:0]), 64'(rd));
      check_val("intrvl out", 64'(wr[15:0]), 64'(csr_txcrdt_intrvl));
      wr = lcg_next() | 32'h1;     // keep tx enabled
      write_reg(REG_TXMODE, wr);
      read_reg(REG_TXMODE, rd);
      check_val("txmode readback", 64'(wr), 64'(rd));
      check_val("txmode outs", 64'({1'b1, wr[4], wr[23:16]}),
                64'({csr_txen, csr_txcrdt_en, csr_txiowidth}));
      write_reg(REG_TXMODE, wr & ~32'h1);
      check_val("txen cleared", 64'd0, 64'(csr_txen));
      wr = lcg_next();
      post_write(REG_CRDTINIT, wr);
      read_reg(REG_CRDTINIT, rd);
      check_val("crdt init readback", 64'(wr), 64'(rd));
      check_val("crdt init outs", 64'(wr), 64'({csr_rxcrdt_resp_init, csr_rxcrdt_req_init}));
      write_reg(REG_STATUS, 32'h0);   // read only
      read_reg(REG_STATUS, rd);
      check_val("status after write", 64'h10, 64'(rd));
      read_reg(8'h3c, rd);
      check_val("unmapped read", 64'd0, 64'(rd));
      wr = lcg_next();
      @(posedge clk);
      csr_txcrdt_status <= wr;
      read_reg(REG_CRDTSTAT, rd);
      check_val("crdt status read", 64'(wr), 64'(rd));

      repeat (4) @(negedge clk);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- tb.f
hw/umi_pkg.sv
hw/link_cfg_pkg.sv
hw/reg_bus_if.sv
hw/umi_reg_endpoint.sv
hw/link_state_tracker.sv
hw/link_ctrl_regs.sv
hw/link_ctrl_top.sv
testbench/tb_link_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the link control testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_link_ctrl -o tb_link_ctrl
./obj_dir/tb_link_ctrl | tee sim.log

# result comes from the log
if grep -q "tests failed" sim.log; then
   echo "simulation result: FAIL"
   exit 1
fi
echo "simulation result: PASS"
